//--- hdl/exu_alu.sv
`default_nettype none

module exu_alu (
  input  exu_pkg::word_t   a_i,
  input  exu_pkg::word_t   b_i,
  input  exu_pkg::alu_op_e op_i,
  output exu_pkg::word_t   res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_AND:  res_o = a_i & b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = word_t'($signed(a_i) >>> shamt);
      // compares give 0 or 1
      ALU_SLT:  res_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: res_o = {31'b0, a_i < b_i};
      ALU_SLE:  res_o = {31'b0, $signed(a_i) <= $signed(b_i)};
      ALU_SLEU: res_o = {31'b0, a_i <= b_i};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/exu_csr.sv
`default_nettype none

module exu_csr (
  input  logic               clk,
  input  logic               rst,
  input  exu_pkg::csr_addr_t addr_i,
  output exu_pkg::word_t     rdata_o,
  input  logic               wen_i,
  input  exu_pkg::csr_addr_t waddr_i,
  input  exu_pkg::word_t     wdata_i,
  input  logic               ecall_i,
  input  exu_pkg::word_t     epc_i,
  output exu_pkg::word_t     mepc_o,
  output exu_pkg::word_t     mtvec_o
);
  import exu_pkg::*;

  word_t mstatus_q;
  word_t mepc_q;
  word_t mcause_q;
  word_t mtvec_q;

  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      default:     rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtvec_q   <= '0;
    end else begin
      if (wen_i) begin
        case (waddr_i)
          CSR_MSTATUS: mstatus_q <= wdata_i;
          CSR_MEPC:    mepc_q    <= wdata_i;
          CSR_MCAUSE:  mcause_q  <= wdata_i;
          CSR_MTVEC:   mtvec_q   <= wdata_i;
          default:     ;
        endcase
      end
      // ecall side port, wins over a general write of mepc
      if (ecall_i) begin
        mepc_q <= epc_i;
      end
    end
  end

  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

endmodule

`default_nettype wire

//--- hdl/exu_lsu.sv
`default_nettype none

module exu_lsu #(
  parameter int MEM_WORDS   = 64,
  parameter int MEM_LATENCY = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           avalid_i,
  input  logic           we_i,
  input  exu_pkg::word_t addr_i,
  input  exu_pkg::word_t wdata_i,
  output exu_pkg::word_t rdata_o,
  output logic           rvalid_o,
  output logic           wready_o
);
  import exu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  word_t            mem [MEM_WORDS];
  word_t            rdata_q;
  logic [IDX_W-1:0] idx;
  logic [CNT_W-1:0] cnt_q;
  logic             busy_q;
  logic             rvalid_q;
  logic             wready_q;
  logic             fire;

  assign idx  = addr_i[2 +: IDX_W];
  assign fire = busy_q && (cnt_q == '0);

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      cnt_q    <= '0;
      rvalid_q <= 1'b0;
      wready_q <= 1'b0;
    end else begin
      rvalid_q <= fire && !we_i;
      wready_q <= fire && we_i;
      if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else if (avalid_i && !rvalid_q && !wready_q) begin
        // request still high in the response cycle, so not restarted
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(MEM_LATENCY - 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (we_i) begin
        mem[idx] <= wdata_i;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;
  assign wready_o = wready_q;

endmodule

`default_nettype wire

//--- hdl/exu_pkg.sv
`default_nettype none

package exu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    OP_ALU,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_CSR,
    OP_ECALL,
    OP_MRET
  } op_class_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLE,
    ALU_SLEU
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_fn_e;

  // taken when the alu result is zero / nonzero
  typedef enum logic [1:0] {
    BR_ZERO,
    BR_NONZERO
  } branch_cond_e;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam word_t MCAUSE_ECALL = 32'd11;

  typedef struct packed {
    op_class_e    op_class;
    alu_op_e      alu_op;
    csr_fn_e      csr_fn;
    branch_cond_e br_cond;
    reg_idx_t     rd;
    word_t        pc;
    word_t        src1;
    word_t        src2;
    word_t        base;
    word_t        imm;
  } issue_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    wdata;
    logic     redirect;
    word_t    redirect_pc;
  } result_t;

endpackage

`default_nettype wire

//--- hdl/exu_stage.sv
`default_nettype none

module exu_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  exu_pkg::issue_t  issue_i,
  output logic             res_valid_o,
  input  logic             res_ready_i,
  output exu_pkg::result_t res_o,
  output logic             mem_avalid_o,
  output logic             mem_we_o,
  output exu_pkg::word_t   mem_addr_o,
  output exu_pkg::word_t   mem_wdata_o,
  input  exu_pkg::word_t   mem_rdata_i,
  input  logic             mem_rvalid_i,
  input  logic             mem_wready_i
);
  import exu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    MEM_WAIT,
    HOLD
  } state_e;

  state_e    state_q;
  issue_t    op_q;
  word_t     ld_data_q;
  logic      avalid_q;
  logic      accept;
  logic      res_fire;
  logic      mem_done;
  logic      is_mem_in;
  logic      csr_wen;
  logic      ecall_fire;
  word_t     alu_res;
  word_t     target;
  word_t     link_pc;
  word_t     csr_rdata;
  word_t     csr_wdata;
  word_t     mepc;
  word_t     mtvec;
  csr_addr_t csr_raddr;
  csr_addr_t csr_waddr;
  word_t     wdata;
  logic      redirect;
  word_t     redirect_pc;

  assign in_ready_o  = (state_q == IDLE) || (state_q == HOLD && res_ready_i);
  assign res_valid_o = (state_q == HOLD);
  assign accept      = in_valid_i && in_ready_o;
  assign res_fire    = res_valid_o && res_ready_i;
  assign is_mem_in   = issue_i.op_class inside {OP_LOAD, OP_STORE};
  assign mem_done    = avalid_q && (mem_we_o ? mem_wready_i : mem_rvalid_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= IDLE;
      avalid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE, HOLD: begin
          if (accept) begin
            state_q  <= is_mem_in ? MEM_WAIT : HOLD;
            avalid_q <= is_mem_in;
          end else if (res_fire) begin
            state_q <= IDLE;
          end
        end
        MEM_WAIT: begin
          if (mem_done) begin
            state_q  <= HOLD;
            avalid_q <= 1'b0;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= issue_i;
    end
    if (mem_done && !mem_we_o) begin
      ld_data_q <= mem_rdata_i;
    end
  end

  exu_alu i_alu (
    .a_i   (op_q.src1),
    .b_i   (op_q.src2),
    .op_i  (op_q.alu_op),
    .res_o (alu_res)
  );

  assign target  = op_q.base + op_q.imm;
  assign link_pc = op_q.pc + 32'd4;

  // mret reads mstatus, everything else the csr in imm
  assign csr_raddr  = (op_q.op_class == OP_MRET) ? CSR_MSTATUS : op_q.imm[11:0];
  assign csr_wen    = res_fire && (op_q.op_class inside {OP_CSR, OP_ECALL, OP_MRET});
  assign ecall_fire = res_fire && (op_q.op_class == OP_ECALL);

  always_comb begin
    csr_waddr = csr_raddr;
    csr_wdata = op_q.src1;
    case (op_q.op_class)
      OP_CSR: begin
        case (op_q.csr_fn)
          CSR_RS:  csr_wdata = csr_rdata | op_q.src1;
          CSR_RC:  csr_wdata = csr_rdata & ~op_q.src1;
          default: csr_wdata = op_q.src1;
        endcase
      end
      OP_ECALL: begin
        csr_waddr = CSR_MCAUSE;
        csr_wdata = MCAUSE_ECALL;
      end
      // set bit 7, old bit 7 moves to bit 3
      OP_MRET: csr_wdata = {csr_rdata[31:8], 1'b1, csr_rdata[6:4], csr_rdata[7], csr_rdata[2:0]};
      default: ;
    endcase
  end

  exu_csr i_csr (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (csr_raddr),
    .rdata_o (csr_rdata),
    .wen_i   (csr_wen),
    .waddr_i (csr_waddr),
    .wdata_i (csr_wdata),
    .ecall_i (ecall_fire),
    .epc_i   (op_q.pc),
    .mepc_o  (mepc),
    .mtvec_o (mtvec)
  );

  always_comb begin
    wdata       = '0;
    redirect    = 1'b0;
    redirect_pc = target;
    case (op_q.op_class)
      OP_ALU:    wdata = alu_res;
      OP_BRANCH: begin
        if (op_q.br_cond == BR_ZERO) begin
          redirect = (alu_res == '0);
        end else begin
          redirect = (alu_res != '0);
        end
      end
      OP_JAL: begin
        wdata    = link_pc;
        redirect = 1'b1;
      end
      OP_JALR: begin
        wdata       = link_pc;
        redirect    = 1'b1;
        redirect_pc = {target[31:1], 1'b0};
      end
      OP_LOAD:   wdata = ld_data_q;
      OP_CSR:    wdata = csr_rdata;
      OP_ECALL: begin
        redirect    = 1'b1;
        redirect_pc = mtvec;
      end
      OP_MRET: begin
        redirect    = 1'b1;
        redirect_pc = mepc;
      end
      default: ;
    endcase
  end

  // x0 never carries data, no target unless redirecting
  assign res_o = '{
    rd:          op_q.rd,
    wdata:       (op_q.rd != '0) ? wdata : '0,
    redirect:    redirect,
    redirect_pc: redirect ? redirect_pc : '0
  };

  assign mem_avalid_o = avalid_q;
  assign mem_we_o     = (op_q.op_class == OP_STORE);
  assign mem_addr_o   = target;
  assign mem_wdata_o  = op_q.src2;

endmodule

`default_nettype wire

//--- hdl/exu_top.sv
`default_nettype none

module exu_top #(
  parameter int MEM_WORDS   = 64,
  parameter int MEM_LATENCY = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  exu_pkg::issue_t  issue_i,
  output logic             res_valid_o,
  input  logic             res_ready_i,
  output exu_pkg::result_t res_o
);
  import exu_pkg::*;

  logic  mem_avalid;
  logic  mem_we;
  word_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic  mem_rvalid;
  logic  mem_wready;

  exu_stage i_stage (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .issue_i      (issue_i),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_o        (res_o),
    .mem_avalid_o (mem_avalid),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .mem_rvalid_i (mem_rvalid),
    .mem_wready_i (mem_wready)
  );

  exu_lsu #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) i_lsu (
    .clk      (clk),
    .rst      (rst),
    .avalid_i (mem_avalid),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (mem_rdata),
    .rvalid_o (mem_rvalid),
    .wready_o (mem_wready)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_exu_top \
  -f sim.f -o tb_exu_top \
  && ./obj_dir/tb_exu_top | tee /dev/stderr | grep -Fx '** PASS **' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim.f
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_csr.sv
hdl/exu_stage.sv
hdl/exu_lsu.sv
hdl/exu_top.sv
tb/exu_assert.sv
tb/tb_exu_top.sv

//--- tb/exu_assert.sv
`default_nettype none

module exu_assert (
  input logic             clk,
  input logic             rst,
  input logic             in_ready_i,
  input logic             res_valid_i,
  input logic             res_ready_i,
  input exu_pkg::result_t res_i,
  input logic             avalid_i,
  input logic             we_i,
  input exu_pkg::word_t   addr_i,
  input exu_pkg::word_t   wdata_i,
  input logic             rvalid_i,
  input logic             wready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic resp;

  // response that matches the pending request
  assign resp = we_i ? wready_i : rvalid_i;

  req_held: assert property (@(posedge clk) disable iff (rst)
    avalid_i && !resp |=> avalid_i && $stable(we_i) && $stable(addr_i) && $stable(wdata_i))
    else $error("memory request dropped or changed before its response");

  res_stable: assert property (@(posedge clk) disable iff (rst)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else $error("result changed or vanished while stalled downstream");

  // avalid high means the stage sits in MEM_WAIT
  no_accept_in_mem_wait: assert property (@(posedge clk) disable iff (rst)
    avalid_i |-> !in_ready_i)
    else $error("stage ready for input while a memory access is pending");

endmodule

bind exu_stage exu_assert i_exu_assert (
  .clk         (clk),
  .rst         (rst),
  .in_ready_i  (in_ready_o),
  .res_valid_i (res_valid_o),
  .res_ready_i (res_ready_i),
  .res_i       (res_o),
  .avalid_i    (mem_avalid_o),
  .we_i        (mem_we_o),
  .addr_i      (mem_addr_o),
  .wdata_i     (mem_wdata_o),
  .rvalid_i    (mem_rvalid_i),
  .wready_i    (mem_wready_i)
);

`default_nettype wire

//--- tb/tb_exu_top.sv
`default_nettype none

module tb_exu_top;
  timeunit 1ns;
  timeprecision 1ps;
  import exu_pkg::*;

  localparam int MEM_WORDS   = 64;
  localparam int MEM_LATENCY = 2;
  localparam int IDX_W       = $clog2(MEM_WORDS);
  localparam int N_RANDOM    = 200;
  localparam int TIMEOUT     = 100;
  localparam csr_addr_t CSR_LIST [4] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};

  logic    clk;
  logic    rst;
  logic    in_valid_i;
  logic    in_ready_o;
  issue_t  issue_i;
  logic    res_valid_o;
  logic    res_ready_i;
  result_t res_o;

  logic    ready_rand;
  int      n_done;
  int      waited;
  issue_t  ops[$];
  issue_t  pending[$];
  issue_t  cmp_op;
  result_t cmp_exp;
  word_t   lfsr_q;
  word_t   ram_m [MEM_WORDS];
  word_t   mstatus_m;
  word_t   mtvec_m;
  word_t   mepc_m;
  word_t   mcause_m;

  exu_top #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) i_exu_top (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .issue_i     (issue_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

  always #20 clk = ~clk;

  task automatic abort_test(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    abort_test($sformatf("Error %s got %h expected %h", name, got, exp));
  endtask

  // galois lfsr stepped once per bit
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    int signed sa;
    int signed sb;
    sa = a;
    sb = b;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'(sa >>> b[4:0]);
      ALU_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SLE:  return (sa <= sb) ? 32'd1 : 32'd0;
      ALU_SLEU: return (a <= b) ? 32'd1 : 32'd0;
      default:  return 32'd0;
    endcase
  endfunction

  function automatic word_t csr_read(input csr_addr_t a);
    case (a)
      CSR_MSTATUS: return mstatus_m;
      CSR_MTVEC:   return mtvec_m;
      CSR_MEPC:    return mepc_m;
      CSR_MCAUSE:  return mcause_m;
      default:     return 32'd0;
    endcase
  endfunction

  function automatic void csr_write(input csr_addr_t a, input word_t v);
    case (a)
      CSR_MSTATUS: mstatus_m = v;
      CSR_MTVEC:   mtvec_m   = v;
      CSR_MEPC:    mepc_m    = v;
      CSR_MCAUSE:  mcause_m  = v;
      default:     ;
    endcase
  endfunction

  function automatic result_t expected_result(input issue_t op);
    result_t r;
    word_t   tgt;
    word_t   data;
    word_t   dest;
    logic    taken;
    tgt   = op.base + op.imm;
    data  = '0;
    dest  = tgt;
    taken = 1'b0;
    case (op.op_class)
      OP_ALU:    data = alu_model(op.alu_op, op.src1, op.src2);
      OP_BRANCH: taken = (alu_model(op.alu_op, op.src1, op.src2) == '0) == (op.br_cond == BR_ZERO);
      OP_JAL: begin
        data  = op.pc + 32'd4;
        taken = 1'b1;
      end
      OP_JALR: begin
        data  = op.pc + 32'd4;
        taken = 1'b1;
        dest  = tgt & ~32'd1;
      end
      OP_LOAD:   data = ram_m[tgt[2 +: IDX_W]];
      OP_CSR:    data = csr_read(op.imm[11:0]);
      OP_ECALL: begin
        taken = 1'b1;
        dest  = mtvec_m;
      end
      OP_MRET: begin
        taken = 1'b1;
        dest  = mepc_m;
      end
      default: ;
    endcase
    r.rd          = op.rd;
    r.wdata       = (op.rd == '0) ? 32'd0 : data;
    r.redirect    = taken;
    r.redirect_pc = taken ? dest : 32'd0;
    return r;
  endfunction

  // memory and csr side effects of each transferred result
  function automatic void apply_effects(input issue_t op);
    word_t     old;
    word_t     tgt;
    csr_addr_t a;
    a   = op.imm[11:0];
    old = csr_read(a);
    tgt = op.base + op.imm;
    case (op.op_class)
      OP_STORE: ram_m[tgt[2 +: IDX_W]] = op.src2;
      OP_CSR: begin
        case (op.csr_fn)
          CSR_RS:  csr_write(a, old | op.src1);
          CSR_RC:  csr_write(a, old & ~op.src1);
          default: csr_write(a, op.src1);
        endcase
      end
      OP_ECALL: begin
        mepc_m   = op.pc;
        mcause_m = 32'd11;
      end
      OP_MRET: mstatus_m = (mstatus_m & ~32'h88) | 32'h80 | (mstatus_m[7] ? 32'h8 : 32'h0);
      default: ;
    endcase
  endfunction

  function automatic issue_t make_op(input op_class_e cls, input reg_idx_t rd, input word_t s1,
                                     input word_t s2, input word_t base, input word_t imm);
    issue_t op;
    op          = '0;
    op.op_class = cls;
    op.rd       = rd;
    op.pc       = 32'h0000_0100;
    op.src1     = s1;
    op.src2     = s2;
    op.base     = base;
    op.imm      = imm;
    return op;
  endfunction

  function automatic issue_t csr_op(input csr_fn_e fn, input csr_addr_t a, input reg_idx_t rd,
                                    input word_t s1);
    issue_t op;
    op        = make_op(OP_CSR, rd, s1, '0, '0, {20'h0, a});
    op.csr_fn = fn;
    return op;
  endfunction

  function automatic issue_t random_op();
    issue_t op;
    op          = '0;
    op.op_class = op_class_e'(4'(rand_bits(4) % 9));
    op.alu_op   = alu_op_e'(4'(rand_bits(4) % 12));
    op.csr_fn   = csr_fn_e'(2'(rand_bits(2) % 3));
    op.br_cond  = branch_cond_e'(2'(rand_bits(1)));
    op.rd       = reg_idx_t'(rand_bits(4));
    op.pc       = rand_bits(30) << 2;
    op.src1     = rand_bits(32);
    op.src2     = rand_bits(32);
    op.base     = rand_bits(32);
    op.imm      = rand_bits(32);
    // equal operands now and then so zero results occur
    if (rand_bits(2) == '0) begin
      op.src2 = op.src1;
    end
    case (op.op_class)
      OP_LOAD, OP_STORE: begin
        op.base = 32'h0000_1000 + (rand_bits(2) << 2);
        op.imm  = rand_bits(2) << 2;
      end
      OP_CSR:  op.imm = (rand_bits(20) << 12) | {20'h0, CSR_LIST[2'(rand_bits(2))]};
      default: ;
    endcase
    return op;
  endfunction

  task automatic load_directed_ops();
    issue_t op;
    // every alu op once with add writing x0
    for (int k = 0; k < 12; k++) begin
      op        = make_op(OP_ALU, reg_idx_t'(k), '0, '0, '0, '0);
      op.alu_op = alu_op_e'(4'(k));
      op.src1   = rand_bits(32);
      op.src2   = rand_bits(32);
      ops.push_back(op);
    end
    ops.push_back(csr_op(CSR_RW, CSR_MTVEC, 4'd1, 32'h0000_0200));
    ops.push_back(csr_op(CSR_RS, CSR_MTVEC, 4'd2, 32'h0000_0003));
    ops.push_back(csr_op(CSR_RC, CSR_MTVEC, 4'd3, 32'h0000_0001));
    ops.push_back(csr_op(CSR_RS, CSR_MTVEC, 4'd4, 32'h0));
    ops.push_back(csr_op(CSR_RW, CSR_MSTATUS, 4'd5, 32'h0000_0080));
    ops.push_back(csr_op(CSR_RS, CSR_MSTATUS, 4'd6, 32'h0000_0008));
    ops.push_back(csr_op(CSR_RC, CSR_MSTATUS, 4'd7, 32'h0000_0080));
    op    = make_op(OP_ECALL, 4'd0, '0, '0, '0, '0);
    op.pc = 32'h0000_0440;
    ops.push_back(op);
    ops.push_back(csr_op(CSR_RS, CSR_MEPC, 4'd8, 32'h0));
    ops.push_back(csr_op(CSR_RS, CSR_MCAUSE, 4'd9, 32'h0));
    ops.push_back(make_op(OP_MRET, 4'd0, '0, '0, '0, '0));
    ops.push_back(csr_op(CSR_RS, CSR_MSTATUS, 4'd10, 32'h0));
    ops.push_back(make_op(OP_STORE, 4'd0, '0, 32'hcafe_0001, 32'h0000_1010, 32'h4));
    ops.push_back(make_op(OP_STORE, 4'd3, '0, 32'hcafe_0002, 32'h0000_1010, 32'h8));
    ops.push_back(make_op(OP_LOAD, 4'd11, '0, '0, 32'h0000_1014, 32'h0));
    ops.push_back(make_op(OP_LOAD, 4'd12, '0, '0, 32'h0000_1010, 32'h8));
    ops.push_back(make_op(OP_LOAD, 4'd13, '0, '0, 32'h0000_1020, 32'h0));
    // beq taken, bne not taken, blt taken
    op         = make_op(OP_BRANCH, 4'd0, 32'h1234, 32'h1234, 32'h0000_0100, 32'h40);
    op.alu_op  = ALU_SUB;
    op.br_cond = BR_ZERO;
    ops.push_back(op);
    op.alu_op  = ALU_XOR;
    op.br_cond = BR_NONZERO;
    ops.push_back(op);
    op.alu_op  = ALU_SLT;
    op.src1    = 32'hffff_fff0;
    op.src2    = 32'h0000_0010;
    ops.push_back(op);
    ops.push_back(make_op(OP_JAL, 4'd1, '0, '0, 32'h0000_0100, 32'h20));
    ops.push_back(make_op(OP_JALR, 4'd2, '0, '0, 32'h0000_0301, 32'h4));
  endtask

  task automatic issue_op(input issue_t op);
    int   wait_cnt;
    logic accepted;
    wait_cnt = 0;
    accepted = 1'b0;
    @(posedge clk);
    #2;
    in_valid_i = 1'b1;
    issue_i    = op;
    while (!accepted) begin
      @(negedge clk);
      if (in_ready_o) begin
        accepted = 1'b1;
        pending.push_back(op);
      end else if (wait_cnt == TIMEOUT) begin
        abort_test("operation never accepted by the execute stage");
      end else begin
        wait_cnt++;
      end
    end
  endtask

  // random back-pressure downstream
  always @(posedge clk) begin
    if (ready_rand) begin
      #2;
      res_ready_i = (rand_bits(2) != '0);
    end
  end

  // a result seen at the falling edge transfers on the next rising edge
  always @(negedge clk) begin
    if (!rst && res_valid_o && res_ready_i) begin
      assert (pending.size() > 0) else abort_test("result returned with nothing outstanding");
      cmp_op  = pending.pop_front();
      cmp_exp = expected_result(cmp_op);
      assert (res_o.rd == cmp_exp.rd)
        else report_mismatch("res_o.rd", 32'(res_o.rd), 32'(cmp_exp.rd));
      assert (res_o.wdata == cmp_exp.wdata)
        else report_mismatch("res_o.wdata", res_o.wdata, cmp_exp.wdata);
      assert (res_o.redirect == cmp_exp.redirect)
        else report_mismatch("res_o.redirect", 32'(res_o.redirect), 32'(cmp_exp.redirect));
      assert (res_o.redirect_pc == cmp_exp.redirect_pc)
        else report_mismatch("res_o.redirect_pc", res_o.redirect_pc, cmp_exp.redirect_pc);
      apply_effects(cmp_op);
      n_done++;
    end
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    issue_i     = '0;
    res_ready_i = 1'b0;
    ready_rand  = 1'b0;
    n_done      = 0;
    lfsr_q      = 32'h9827_f937;
    mstatus_m   = '0;
    mtvec_m     = '0;
    mepc_m      = '0;
    mcause_m    = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ram_m[i] = '0;
    end
    load_directed_ops();
    for (int i = 0; i < N_RANDOM; i++) begin
      ops.push_back(random_op());
    end
    repeat (4) @(posedge clk);
    #2;
    rst        = 1'b0;
    ready_rand = 1'b1;
    assert (!res_valid_o && in_ready_o) else abort_test("stage not idle after reset");
    foreach (ops[i]) begin
      issue_op(ops[i]);
    end
    @(posedge clk);
    #2;
    in_valid_i = 1'b0;
    waited     = 0;
    while (n_done < ops.size()) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        abort_test("results stopped arriving before the last operation");
      end
    end
    // stage has nothing left once the last result has left
    @(negedge clk);
    if (!res_valid_o && n_done == ops.size()) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_test("stage produced a result beyond the issued operations");
    end
  end

endmodule

`default_nettype wire
